// File: common/vid_pkg.sv
`default_nettype none

package vid_pkg;

    // stream widths
    localparam int BYTE_W = 8;              // camera byte and RGB888 channel
    localparam int PIX_W  = 16;             // one RGB565 pixel

    // RGB565 channel widths
    localparam int R_W = 5;
    localparam int G_W = 6;
    localparam int B_W = 5;

    // displayed source codes
    localparam logic [1:0] SRC_CAM1 = 2'd0;
    localparam logic [1:0] SRC_CAM2 = 2'd1;
    localparam logic [1:0] SRC_HDMI = 2'd2; // highest legal code

    // upper nibble of the command byte
    localparam logic [3:0] CTRL_SRC = 4'd1; // value nibble picks the source
    localparam logic [3:0] CTRL_EN  = 4'd2; // value bit 0 enables the output

    // one camera word, read two ways
    // the sensor sends blue in the high bits and red in the low bits
    typedef union packed {
        struct packed {
            logic [BYTE_W-1:0] hi;          // first byte of a pair
            logic [BYTE_W-1:0] lo;          // second byte
        } bytes;
        struct packed {
            logic [B_W-1:0] blue;           // swapped by the sensor
            logic [G_W-1:0] green;
            logic [R_W-1:0] red;
        } fields;
    } cam_word_u;

endpackage

`default_nettype wire

// File: hw/vid_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module vid_ctrl
    import vid_pkg::*;
#(
    parameter int STARTUP_CYCLES = 10000,   // power-on delay in core_clk cycles
    parameter int HB_PERIOD      = 33000000 // heartbeat count threshold
) (
    input  wire logic              core_clk,
    input  wire logic              rst_i,
    input  wire logic              cmd_valid_i,    // one-cycle strobe
    input  wire logic [BYTE_W-1:0] cmd_byte_i,     // {ctrl, value}
    output logic      [1:0]        sel_src_o,      // to pix_select
    output logic                   out_en_o,       // to pix_select
    output logic                   ready_o,
    output logic                   heartbeat_o,
    output logic                   cmd_err_o       // one-cycle pulse
);

    localparam int SU_W = $clog2(STARTUP_CYCLES + 1);
    localparam int HB_W = $clog2(HB_PERIOD + 1);

    logic [SU_W-1:0] su_cnt;                // power-on counter
    logic [HB_W-1:0] hb_cnt;                // heartbeat counter
    logic [3:0]      cmd_ctrl;              // control channel
    logic [3:0]      cmd_val;               // value channel
    logic            cmd_take;

    assign cmd_ctrl = cmd_byte_i[BYTE_W-1:4];
    assign cmd_val  = cmd_byte_i[3:0];
    assign cmd_take = cmd_valid_i && ready_o; // nothing accepted before ready

    // power-on delay, ready stays high once set
    always_ff @(posedge core_clk) begin
        if (rst_i) begin
            su_cnt  <= '0;
            ready_o <= 1'b0;
        end else if (!ready_o) begin
            if (su_cnt == SU_W'(STARTUP_CYCLES - 1)) begin
                ready_o <= 1'b1;            // S edges after reset release
            end else begin
                su_cnt <= su_cnt + 1'b1;
            end
        end
    end

    // command decoder with source and enable registers
    always_ff @(posedge core_clk) begin
        if (rst_i) begin
            sel_src_o <= SRC_CAM1;          // camera 1 shown after reset
            out_en_o  <= 1'b1;
            cmd_err_o <= 1'b0;
        end else begin
            cmd_err_o <= 1'b0;              // pulse only
            if (cmd_take) begin
                case (cmd_ctrl)
                    CTRL_SRC: begin
                        if (cmd_val <= {2'b00, SRC_HDMI}) begin
                            sel_src_o <= cmd_val[1:0];
                        end else begin
                            cmd_err_o <= 1'b1;  // no such source
                        end
                    end
                    CTRL_EN: begin
                        out_en_o <= cmd_val[0]; // upper value bits ignored
                    end
                    default: begin
                        cmd_err_o <= 1'b1;  // unknown control code
                    end
                endcase
            end
        end
    end

    // heartbeat, held high until ready
    // toggle spacing is HB_PERIOD + 1 cycles
    always_ff @(posedge core_clk) begin
        if (rst_i) begin
            hb_cnt      <= '0;
            heartbeat_o <= 1'b1;
        end else if (!ready_o) begin
            hb_cnt      <= '0;
            heartbeat_o <= 1'b1;
        end else if (hb_cnt == HB_W'(HB_PERIOD)) begin
            hb_cnt      <= '0;              // wrap and toggle
            heartbeat_o <= ~heartbeat_o;
        end else begin
            hb_cnt <= hb_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/cam/cam_byte_pack.sv
`timescale 1ns/1ps
`default_nettype none

module cam_byte_pack
    import vid_pkg::*;
(
    input  wire logic              core_clk,
    input  wire logic              rst_i,
    input  wire logic              href_i,      // byte valid level
    input  wire logic              vsync_i,
    input  wire logic [BYTE_W-1:0] data_i,
    output logic      [PIX_W-1:0]  pix_o,       // RGB565, red on top
    output logic                   pix_valid_o, // one cycle after the lo byte
    output logic                   vsync_o      // vsync_i, one cycle late
);

    logic              phase;                   // 1 while waiting for lo
    logic              byte_take;
    logic [BYTE_W-1:0] hi_q;                    // first byte of the pair
    cam_word_u         word_c;                  // pair as seen on the bus
    logic [PIX_W-1:0]  pix_c;

    // a byte only counts inside a line and outside vsync
    assign byte_take = href_i && !vsync_i;

    // assemble through the byte view
    assign word_c.bytes.hi = hi_q;
    assign word_c.bytes.lo = data_i;

    // read back through the field view, red and blue swapped into place
    assign pix_c = {word_c.fields.red, word_c.fields.green, word_c.fields.blue};

    // byte phase
    always_ff @(posedge core_clk) begin
        if (rst_i) begin
            phase <= 1'b0;
        end else if (!byte_take) begin
            phase <= 1'b0;                      // href low or vsync clears
        end else begin
            phase <= ~phase;
        end
    end

    // hi byte holding register
    always_ff @(posedge core_clk) begin
        if (byte_take && !phase) begin
            hi_q <= data_i;
        end
    end

    // pixel output stage
    always_ff @(posedge core_clk) begin
        if (rst_i) begin
            pix_valid_o <= 1'b0;
            vsync_o     <= 1'b0;
        end else begin
            pix_valid_o <= byte_take && phase;  // lo byte completes the pixel
            vsync_o     <= vsync_i;
        end
    end

    always_ff @(posedge core_clk) begin
        if (byte_take && phase) begin
            pix_o <= pix_c;
        end
    end

endmodule

`default_nettype wire

// File: hw/pix_select.sv
`timescale 1ns/1ps
`default_nettype none

module pix_select
    import vid_pkg::*;
(
    input  wire logic              core_clk,
    input  wire logic              rst_i,
    input  wire logic [1:0]        sel_src_i,
    input  wire logic              out_en_i,
    input  wire logic [PIX_W-1:0]  cam1_pix_i,
    input  wire logic              cam1_valid_i,
    input  wire logic              cam1_vs_i,
    input  wire logic [PIX_W-1:0]  cam2_pix_i,
    input  wire logic              cam2_valid_i,
    input  wire logic              cam2_vs_i,
    input  wire logic              hdmi_de_i,
    input  wire logic              hdmi_vs_i,
    input  wire logic [BYTE_W-1:0] hdmi_r_i,
    input  wire logic [BYTE_W-1:0] hdmi_g_i,
    input  wire logic [BYTE_W-1:0] hdmi_b_i,
    output logic                   vs_o,
    output logic                   de_o,
    output logic      [BYTE_W-1:0] r_o,
    output logic      [BYTE_W-1:0] g_o,
    output logic      [BYTE_W-1:0] b_o
);

    logic [PIX_W-1:0]  hdmi_pix;        // HDMI cut down to RGB565
    logic [PIX_W-1:0]  sel_pix;
    logic              sel_valid;
    logic              sel_vs;
    logic [R_W-1:0]    sel_r;
    logic [G_W-1:0]    sel_g;
    logic [B_W-1:0]    sel_b;
    logic [BYTE_W-1:0] exp_r;
    logic [BYTE_W-1:0] exp_g;
    logic [BYTE_W-1:0] exp_b;
    logic              show;

    // keep the top bits of each colour
    assign hdmi_pix = {hdmi_r_i[BYTE_W-1 -: R_W],
                       hdmi_g_i[BYTE_W-1 -: G_W],
                       hdmi_b_i[BYTE_W-1 -: B_W]};

    // source mux
    always_comb begin
        case (sel_src_i)
            SRC_CAM1: begin
                sel_pix   = cam1_pix_i;
                sel_valid = cam1_valid_i;
                sel_vs    = cam1_vs_i;
            end
            SRC_CAM2: begin
                sel_pix   = cam2_pix_i;
                sel_valid = cam2_valid_i;
                sel_vs    = cam2_vs_i;
            end
            SRC_HDMI: begin
                sel_pix   = hdmi_pix;
                sel_valid = hdmi_de_i;      // one pixel per de cycle
                sel_vs    = hdmi_vs_i;
            end
            default: begin
                sel_pix   = '0;             // unused code, nothing shown
                sel_valid = 1'b0;
                sel_vs    = 1'b0;
            end
        endcase
    end

    // split RGB565
    assign sel_r = sel_pix[PIX_W-1 -: R_W];
    assign sel_g = sel_pix[B_W +: G_W];
    assign sel_b = sel_pix[B_W-1:0];

    // expand to RGB888 by repeating the top bits
    assign exp_r = {sel_r, sel_r[R_W-1 -: BYTE_W-R_W]};
    assign exp_g = {sel_g, sel_g[G_W-1 -: BYTE_W-G_W]};
    assign exp_b = {sel_b, sel_b[B_W-1 -: BYTE_W-B_W]};

    assign show = sel_valid && out_en_i;

    // output registers, colour is zero outside de
    always_ff @(posedge core_clk) begin
        if (rst_i) begin
            vs_o <= 1'b0;
            de_o <= 1'b0;
            r_o  <= '0;
            g_o  <= '0;
            b_o  <= '0;
        end else begin
            vs_o <= sel_vs;
            de_o <= show;
            r_o  <= show ? exp_r : '0;
            g_o  <= show ? exp_g : '0;
            b_o  <= show ? exp_b : '0;
        end
    end

endmodule

`default_nettype wire

// File: hw/vid_top.sv
`timescale 1ns/1ps
`default_nettype none

module vid_top
    import vid_pkg::*;
#(
    parameter int STARTUP_CYCLES = 10000,
    parameter int HB_PERIOD      = 33000000
) (
    input  wire logic              core_clk,
    input  wire logic              rst_i,
    // command byte
    input  wire logic              cmd_valid_i,
    input  wire logic [BYTE_W-1:0] cmd_byte_i,
    // camera 1
    input  wire logic              cam1_href_i,
    input  wire logic              cam1_vsync_i,
    input  wire logic [BYTE_W-1:0] cam1_data_i,
    // camera 2
    input  wire logic              cam2_href_i,
    input  wire logic              cam2_vsync_i,
    input  wire logic [BYTE_W-1:0] cam2_data_i,
    // HDMI in, RGB888
    input  wire logic              hdmi_de_i,
    input  wire logic              hdmi_vs_i,
    input  wire logic [BYTE_W-1:0] hdmi_r_i,
    input  wire logic [BYTE_W-1:0] hdmi_g_i,
    input  wire logic [BYTE_W-1:0] hdmi_b_i,
    // video out, RGB888
    output logic                   vs_o,
    output logic                   de_o,
    output logic      [BYTE_W-1:0] r_o,
    output logic      [BYTE_W-1:0] g_o,
    output logic      [BYTE_W-1:0] b_o,
    // status
    output logic                   ready_o,
    output logic                   heartbeat_o,
    output logic                   cmd_err_o
);

    logic [1:0]       sel_src;
    logic             out_en;
    logic [PIX_W-1:0] cam1_pix;
    logic             cam1_valid;
    logic             cam1_vs;
    logic [PIX_W-1:0] cam2_pix;
    logic             cam2_valid;
    logic             cam2_vs;

    vid_ctrl #(
        .STARTUP_CYCLES (STARTUP_CYCLES),
        .HB_PERIOD      (HB_PERIOD)
    ) i_vid_ctrl (
        .core_clk    (core_clk),
        .rst_i       (rst_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_byte_i  (cmd_byte_i),
        .sel_src_o   (sel_src),
        .out_en_o    (out_en),
        .ready_o     (ready_o),
        .heartbeat_o (heartbeat_o),
        .cmd_err_o   (cmd_err_o)
    );

    cam_byte_pack i_cam1_pack (
        .core_clk    (core_clk),
        .rst_i       (rst_i),
        .href_i      (cam1_href_i),
        .vsync_i     (cam1_vsync_i),
        .data_i      (cam1_data_i),
        .pix_o       (cam1_pix),
        .pix_valid_o (cam1_valid),
        .vsync_o     (cam1_vs)
    );

    cam_byte_pack i_cam2_pack (
        .core_clk    (core_clk),
        .rst_i       (rst_i),
        .href_i      (cam2_href_i),
        .vsync_i     (cam2_vsync_i),
        .data_i      (cam2_data_i),
        .pix_o       (cam2_pix),
        .pix_valid_o (cam2_valid),
        .vsync_o     (cam2_vs)
    );

    pix_select i_pix_select (
        .core_clk     (core_clk),
        .rst_i        (rst_i),
        .sel_src_i    (sel_src),
        .out_en_i     (out_en),
        .cam1_pix_i   (cam1_pix),
        .cam1_valid_i (cam1_valid),
        .cam1_vs_i    (cam1_vs),
        .cam2_pix_i   (cam2_pix),
        .cam2_valid_i (cam2_valid),
        .cam2_vs_i    (cam2_vs),
        .hdmi_de_i    (hdmi_de_i),
        .hdmi_vs_i    (hdmi_vs_i),
        .hdmi_r_i     (hdmi_r_i),
        .hdmi_g_i     (hdmi_g_i),
        .hdmi_b_i     (hdmi_b_i),
        .vs_o         (vs_o),
        .de_o         (de_o),
        .r_o          (r_o),
        .g_o          (g_o),
        .b_o          (b_o)
    );

endmodule

`default_nettype wire

// File: dv/vid_chk.sv
`timescale 1ns/1ps
`default_nettype none

module vid_chk
    import vid_pkg::*;
(
    input  wire logic              core_clk,
    input  wire logic              rst_i,
    input  wire logic              de_i,
    input  wire logic [BYTE_W-1:0] r_i,
    input  wire logic [BYTE_W-1:0] g_i,
    input  wire logic [BYTE_W-1:0] b_i,
    input  wire logic              ready_i,
    input  wire logic              heartbeat_i,
    input  wire logic              cmd_err_i
);

    // colour must be zero outside de
    a_blank_colour: assert property (@(posedge core_clk) disable iff (rst_i)
        !de_i |-> (r_i == '0 && g_i == '0 && b_i == '0))
        else $error("colour outputs nonzero while de_o is low");

    a_no_err_early: assert property (@(posedge core_clk) disable iff (rst_i)
        !ready_i |-> !cmd_err_i)
        else $error("cmd_err_o high before ready_o");

    a_hb_idle: assert property (@(posedge core_clk) disable iff (rst_i)
        !ready_i |-> heartbeat_i)       // heartbeat parked high until ready
        else $error("heartbeat_o low before ready_o");

endmodule

bind vid_top vid_chk i_vid_chk (
    .core_clk    (core_clk),
    .rst_i       (rst_i),
    .de_i        (de_o),
    .r_i         (r_o),
    .g_i         (g_o),
    .b_i         (b_o),
    .ready_i     (ready_o),
    .heartbeat_i (heartbeat_o),
    .cmd_err_i   (cmd_err_o)
);

`default_nettype wire

// File: dv/vid_tb.sv
`timescale 1ns/1ps
`default_nettype none

module vid_tb
    import vid_pkg::*;
();

    localparam int STARTUP = 40;                // short power-on delay
    localparam int HB      = 25;                // heartbeat threshold
    localparam int TMO     = 12;                // cycles allowed per pixel

    logic              core_clk;
    logic              rst_i;
    logic              cmd_valid_i;
    logic [BYTE_W-1:0] cmd_byte_i;
    logic              cam1_href_i;
    logic              cam1_vsync_i;
    logic              cam2_href_i;
    logic              cam2_vsync_i;
    logic [BYTE_W-1:0] cam1_data_i;
    logic [BYTE_W-1:0] cam2_data_i;
    logic              hdmi_de_i;
    logic              hdmi_vs_i;
    logic [BYTE_W-1:0] hdmi_r_i;
    logic [BYTE_W-1:0] hdmi_g_i;
    logic [BYTE_W-1:0] hdmi_b_i;
    logic              vs_o;
    logic              de_o;
    logic              ready_o;
    logic              heartbeat_o;
    logic              cmd_err_o;
    logic [BYTE_W-1:0] r_o;
    logic [BYTE_W-1:0] g_o;
    logic [BYTE_W-1:0] b_o;

    logic [1:0]        exp_src;                 // source as the tb sees it
    logic              exp_en;
    logic [31:0]       lcg_state;
    logic              hb_done;
    int                mism_cnt = 0;
    int                other_cnt = 0;           // timeouts and file trouble

    vid_top #(.STARTUP_CYCLES(STARTUP), .HB_PERIOD(HB)) i_vid_top (.*);

    always #10 core_clk = ~core_clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // RGB565 channel to 8 bits, top bits repeated below
    function automatic logic [BYTE_W-1:0] widen5(input logic [4:0] v);
        return {v, v[4:2]};
    endfunction

    function automatic logic [BYTE_W-1:0] widen6(input logic [5:0] v);
        return {v, v[5:4]};
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mism_cnt++;
            $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_pix(input logic [BYTE_W-1:0] er, eg, eb);
        if ({r_o, g_o, b_o} !== {er, eg, eb}) begin
            mism_cnt++;
            $display("Mismatch r_o g_o b_o: got %h %h %h expected %h %h %h at %0t",
                     r_o, g_o, b_o, er, eg, eb, $time);
        end
    endtask

    task automatic check_gap(input int got, input int exp);
        if (got != exp) begin
            mism_cnt++;
            $display("Mismatch heartbeat_o spacing: got %h expected %h", got, exp);
        end
    endtask

    // wait for de_o or make sure it stays low
    task automatic expect_pix(input logic shown, input logic [BYTE_W-1:0] er, eg, eb);
        int n;
        n = 0;
        if (shown) begin
            while (de_o !== 1'b1 && n < TMO) begin
                @(negedge core_clk);
                n++;
            end
            if (de_o === 1'b1) begin
                check_pix(er, eg, eb);
            end else begin
                other_cnt++;
                $display("timeout: no de_o for an expected pixel at %0t", $time);
            end
        end else begin
            for (n = 0; n < TMO; n++) begin
                check_bit("de_o", de_o, 1'b0);  // blanked or unselected
                @(negedge core_clk);
            end
        end
    endtask

    task automatic drive_cam(input int cam, input logic href, input logic [BYTE_W-1:0] data);
        if (cam == 1) begin
            cam1_href_i = href;
            cam1_data_i = data;
        end else begin
            cam2_href_i = href;
            cam2_data_i = data;
        end
    endtask

    task automatic drive_vsync(input logic [1:0] src, input logic v);
        case (src)
            SRC_CAM1: cam1_vsync_i = v;
            SRC_CAM2: cam2_vsync_i = v;
            default:  hdmi_vs_i    = v;
        endcase
    endtask

    // one-cycle vsync on a source, only the selected one reaches vs_o
    task automatic pulse_vsync(input logic [1:0] src);
        int n;
        int lat;
        lat = (src == SRC_HDMI) ? 1 : 2;        // camera path adds a register
        @(negedge core_clk);
        drive_vsync(src, 1'b1);
        for (n = 1; n <= 4; n++) begin
            @(negedge core_clk);
            if (n == 1) begin
                drive_vsync(src, 1'b0);
            end
            check_bit("vs_o", vs_o, exp_src == src && n == lat);
        end
    endtask

    task automatic run_cam(input int cam, input logic [BYTE_W-1:0] hi, lo);
        cam_word_u w;
        logic      shown;
        @(negedge core_clk);
        drive_cam(cam, 1'b1, hi);
        @(negedge core_clk);
        drive_cam(cam, 1'b1, lo);
        @(negedge core_clk);
        drive_cam(cam, 1'b0, '0);
        w.bytes.hi = hi;
        w.bytes.lo = lo;
        shown = exp_en && (exp_src == ((cam == 1) ? SRC_CAM1 : SRC_CAM2));
        expect_pix(shown, widen5(w.fields.red), widen6(w.fields.green), widen5(w.fields.blue));
    endtask

    task automatic run_hdmi(input logic [BYTE_W-1:0] r, g, b);
        @(negedge core_clk);
        hdmi_de_i = 1'b1;
        {hdmi_r_i, hdmi_g_i, hdmi_b_i} = {r, g, b};
        @(negedge core_clk);
        hdmi_de_i = 1'b0;
        {hdmi_r_i, hdmi_g_i, hdmi_b_i} = '0;
        expect_pix(exp_en && exp_src == SRC_HDMI, widen5(r[7:3]), widen6(g[7:2]), widen5(b[7:3]));
    endtask

    task automatic run_cmd(input logic [BYTE_W-1:0] cmd, input logic exp_err);
        @(negedge core_clk);
        cmd_valid_i = 1'b1;
        cmd_byte_i  = cmd;
        @(negedge core_clk);
        cmd_valid_i = 1'b0;
        check_bit("cmd_err_o", cmd_err_o, exp_err);
        @(negedge core_clk);
        check_bit("cmd_err_o", cmd_err_o, 1'b0);    // single pulse
        if (cmd[7:4] == CTRL_SRC && cmd[3:0] <= 4'd2) begin
            exp_src = cmd[1:0];
        end else if (cmd[7:4] == CTRL_EN) begin
            exp_en = cmd[0];
        end
    endtask

    // heartbeat spacing, counted from the ready edge
    initial begin : hb_mon
        int   n;
        int   t;
        logic last;
        hb_done = 1'b0;
        n = 0;
        while (ready_o !== 1'b1 && n < 200) begin
            @(negedge core_clk);
            n++;
        end
        if (ready_o !== 1'b1) begin
            other_cnt++;
            $display("timeout: ready_o never rose, heartbeat not checked");
        end else begin
            for (t = 0; t < 4; t++) begin
                last = heartbeat_o;
                n = 0;
                while (heartbeat_o === last && n < 2 * HB + 4) begin
                    @(negedge core_clk);
                    n++;
                end
                check_gap(n, HB + 1);
            end
        end
        hb_done = 1'b1;
    end

    initial begin : main
        int          fd;
        int          n;
        int          code;
        string       line;
        logic [7:0]  kind;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        core_clk = 1'b0;
        rst_i = 1'b1;
        cmd_valid_i = 1'b0;
        cmd_byte_i = '0;
        {cam1_href_i, cam1_vsync_i, cam2_href_i, cam2_vsync_i} = '0;
        {cam1_data_i, cam2_data_i} = '0;
        {hdmi_de_i, hdmi_vs_i, hdmi_r_i, hdmi_g_i, hdmi_b_i} = '0;
        exp_src = SRC_CAM1;
        exp_en = 1'b1;
        lcg_state = 32'h4c43;
        repeat (16) @(negedge core_clk);
        rst_i = 1'b0;
        // power-on window, both commands must be ignored
        for (n = 1; n <= STARTUP; n++) begin
            cmd_valid_i = (n == 5 || n == 6);
            cmd_byte_i  = (n == 5) ? 8'h12 : 8'hf3;
            @(negedge core_clk);
            check_bit("ready_o", ready_o, n == STARTUP);
            check_bit("cmd_err_o", cmd_err_o, 1'b0);
        end
        fd = $fopen("dv/vid_cases.txt", "r");
        if (fd == 0) begin
            other_cnt++;
            $display("could not open dv/vid_cases.txt");
        end
        while (fd != 0 && !$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0 || line.len() < 2 || line[0] == "#") continue;
            code = $sscanf(line, "%c %h %h %h", kind, f1, f2, f3);
            case (kind)
                "C": run_cmd(f1[7:0], f2[0]);
                "P": run_cam(int'(f1), f2[7:0], f3[7:0]);
                "H": run_hdmi(f1[7:0], f2[7:0], f3[7:0]);
                "R": begin
                    for (n = 0; n < int'(f1); n++) begin
                        lcg_state = lcg_next(lcg_state);
                        run_hdmi(lcg_state[31:24], lcg_state[23:16], lcg_state[15:8]);
                    end
                end
                default: begin
                    other_cnt++;
                    $display("unknown case kind in line: %s", line);
                end
            endcase
        end
        if (fd != 0) $fclose(fd);
        // frame sync from every source against the current selection
        pulse_vsync(SRC_CAM1);
        pulse_vsync(SRC_CAM2);
        pulse_vsync(SRC_HDMI);
        n = 0;
        while (!hb_done && n < 400) begin
            @(negedge core_clk);
            n++;
        end
        if (!hb_done) begin
            other_cnt++;
            $display("timeout: heartbeat monitor did not finish");
        end
        $display("mismatches: %0d, other errors: %0d", mism_cnt, other_cnt);
        if (mism_cnt == 0 && other_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/vid_cases.txt
# kind C: cmd_byte exp_err | P: camera hi lo | H: red green blue | R: count
# all fields hex, one case per line
P 1 f8 1f
P 1 07 e0
P 1 a5 5a
P 2 12 34
C 11 0
P 2 f8 00
P 2 00 1f
P 2 c3 3c
P 1 ff ff
H 80 40 20
C 12 0
H ff 00 00
H 00 ff 00
H 00 00 ff
H 12 34 56
R 8
C 20 0
H aa bb cc
P 1 11 22
C 21 0
H aa bb cc
C 51 1
H 01 02 03
C 13 1
H fe dc ba
C 10 0
P 1 9c 63
C 2e 0
P 1 9c 63
C 23 0
P 1 9c 63
C 00 1
P 1 0f f0
C 14 1
P 1 3c c3

// File: vlog.f
common/vid_pkg.sv
hw/vid_ctrl.sv
hw/cam/cam_byte_pack.sv
hw/pix_select.sv
hw/vid_top.sv
dv/vid_chk.sv
dv/vid_tb.sv

// File: run.sh
#!/bin/sh
# build and run the vid_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f vlog.f --top-module vid_tb -Mdir obj_dir; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vvid_tb)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "All checks passed"; then
    exit 0
fi
exit 1
